/* design/control_fsm.sv */
`default_nettype none
`timescale 1ns/10ps

module control_fsm
	import stack_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire opcode_e opcode,
	input wire logic tos_zero,
	output ctrl_t ctrl
);

	state_e state;
	state_e state_next;
	// Set while a BFALSE finishes, the IP already holds its destination
	logic branch_pending;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IADDR_ISSUE;
			branch_pending <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state == DECODE)
				branch_pending <= (opcode == OP_BFALSE);
		end
	end

	always_comb
	begin
		ctrl.sp_sel = SP_CURRENT;
		ctrl.tos_sel = TOS_CURRENT;
		ctrl.ma_sel = MA_IP;
		ctrl.mw_sel = MW_TOS;
		ctrl.ip_sel = IP_CURRENT;
		ctrl.op0_sel = OP0_TOS;
		ctrl.op1_sel = OP1_MEM_READ;
		ctrl.alu_op = opcode;
		ctrl.mem_write_enable = 1'b0;
		ctrl.insn_from_mem = (state == DECODE);
		state_next = state;

		case (state)
			IADDR_ISSUE:
			begin
				ctrl.ip_sel = IP_NEXT;
				state_next = DECODE;
			end

			DECODE:
			begin
				case (opcode)
					OP_POP:
					begin
						// New TOS comes from NOS
						ctrl.ma_sel = MA_SP;
						ctrl.sp_sel = SP_INCREMENT;
						state_next = PUSH_MEM_RESULT;
					end

					OP_LOAD:
					begin
						ctrl.ma_sel = MA_TOS;
						state_next = PUSH_MEM_RESULT;
					end

					OP_STORE, OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
					OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
					begin
						// Read NOS first
						ctrl.ma_sel = MA_SP;
						state_next = GOT_NOS;
					end

					OP_DUP, OP_PUSH:
					begin
						// Spill old TOS to sp - 1
						ctrl.sp_sel = SP_DECREMENT;
						ctrl.ma_sel = MA_ALU;
						ctrl.op0_sel = OP0_SP;
						ctrl.op1_sel = OP1_ONE;
						ctrl.alu_op = OP_SUB;
						ctrl.mem_write_enable = 1'b1;
						ctrl.mw_sel = MW_TOS;
						if (opcode == OP_PUSH)
							ctrl.tos_sel = TOS_PARAM;
						state_next = IADDR_ISSUE;
					end

					OP_GOTO:
					begin
						ctrl.ip_sel = IP_BRANCH;
						state_next = DECODE;
					end

					OP_BFALSE:
					begin
						ctrl.ip_sel = tos_zero ? IP_BRANCH : IP_NEXT;
						ctrl.sp_sel = SP_INCREMENT;
						ctrl.ma_sel = MA_SP;
						state_next = PUSH_MEM_RESULT;
					end

					default:
					begin
						// NOP and anything not implemented
						ctrl.ip_sel = IP_NEXT;
						state_next = DECODE;
					end
				endcase
			end

			GOT_NOS:
			begin
				ctrl.sp_sel = SP_INCREMENT;
				if (opcode == OP_STORE)
				begin
					// NOS goes to the address in TOS, then refill TOS
					ctrl.ma_sel = MA_TOS;
					ctrl.mw_sel = MW_MEM_READ;
					ctrl.mem_write_enable = 1'b1;
					state_next = LOAD_TOS1;
				end
				else
				begin
					ctrl.tos_sel = TOS_ALU_RESULT;
					ctrl.ip_sel = IP_NEXT;
					state_next = DECODE;
				end
			end

			LOAD_TOS1:
			begin
				ctrl.ma_sel = MA_SP;
				ctrl.sp_sel = SP_INCREMENT;
				state_next = PUSH_MEM_RESULT;
			end

			PUSH_MEM_RESULT:
			begin
				ctrl.tos_sel = TOS_MEM_RESULT;
				if (!branch_pending)
					ctrl.ip_sel = IP_NEXT;
				state_next = DECODE;
			end

			default:
			begin
				state_next = IADDR_ISSUE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/insn_align.sv */
`default_nettype none
`timescale 1ns/10ps

module insn_align
	import stack_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire ctrl_t ctrl,
	input wire word_t mem_read_value,
	input wire logic [1:0] slot,
	output opcode_e opcode,
	output data_t param
);

	word_t latched_word;
	word_t current_word;

	// Hold the fetched word for the later cycles of an instruction
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			latched_word <= '0;
		else if (ctrl.insn_from_mem)
			latched_word <= mem_read_value;
	end

	assign current_word = ctrl.insn_from_mem ? mem_read_value : latched_word;

	// Slot 0 sits in the top bits, the parameter is whatever follows it
	always_comb
	begin
		case (slot)
			2'd0:
			begin
				opcode = opcode_e'(current_word[19:15]);
				param = {{1{current_word[14]}}, current_word[14:0]};
			end
			2'd1:
			begin
				opcode = opcode_e'(current_word[14:10]);
				param = {{6{current_word[9]}}, current_word[9:0]};
			end
			2'd2:
			begin
				opcode = opcode_e'(current_word[9:5]);
				param = {{11{current_word[4]}}, current_word[4:0]};
			end
			default:
			begin
				// Last slot has no room for a parameter
				opcode = opcode_e'(current_word[4:0]);
				param = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/lisp_core.sv */
`default_nettype none
`timescale 1ns/10ps

module lisp_core
	import stack_pkg::*;
#(
	parameter data_t STACK_TOP = 16'd8184
)
(
	input wire logic clk,
	input wire logic rst_n,
	output data_t memory_address,
	input wire word_t mem_read_value,
	output word_t mem_write_value,
	output logic mem_write_enable
);

	ctrl_t ctrl;
	opcode_e opcode;
	data_t param;
	data_t alu_result;
	word_t top_of_stack;
	data_t stack_pointer;
	logic [1:0] slot;
	logic tos_zero;

	assign mem_write_enable = ctrl.mem_write_enable;

	control_fsm i_control_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.ctrl(ctrl)
	);

	insn_align i_insn_align (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.mem_read_value(mem_read_value),
		.slot(slot),
		.opcode(opcode),
		.param(param)
	);

	stack_alu i_stack_alu (
		.ctrl(ctrl),
		.top_of_stack(top_of_stack),
		.stack_pointer(stack_pointer),
		.mem_read_value(mem_read_value),
		.param(param),
		.alu_result(alu_result)
	);

	stack_datapath #(
		.STACK_TOP(STACK_TOP)
	) i_stack_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.opcode(opcode),
		.param(param),
		.alu_result(alu_result),
		.mem_read_value(mem_read_value),
		.top_of_stack(top_of_stack),
		.stack_pointer(stack_pointer),
		.slot(slot),
		.tos_zero(tos_zero),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value)
	);

endmodule

`default_nettype wire

/* design/stack_alu.sv */
`default_nettype none
`timescale 1ns/10ps

module stack_alu
	import stack_pkg::*;
(
	input wire ctrl_t ctrl,
	input wire word_t top_of_stack,
	input wire data_t stack_pointer,
	input wire word_t mem_read_value,
	input wire data_t param,
	output data_t alu_result
);

	data_t op0;
	data_t op1;
	data_t diff;
	logic zero;
	logic negative;

	assign op0 = (ctrl.op0_sel == OP0_SP) ? stack_pointer : top_of_stack[DATA_WIDTH-1:0];

	always_comb
	begin
		case (ctrl.op1_sel)
			OP1_MEM_READ: op1 = mem_read_value[DATA_WIDTH-1:0];
			OP1_PARAM: op1 = param;
			OP1_ONE: op1 = data_t'(1);
			default: op1 = '0;
		endcase
	end

	// Compares all come from one subtract
	assign diff = op0 - op1;
	assign zero = (diff == '0);
	assign negative = diff[DATA_WIDTH-1];

	always_comb
	begin
		case (ctrl.alu_op)
			OP_ADD: alu_result = op0 + op1;
			OP_SUB: alu_result = diff;
			OP_GTR: alu_result = data_t'(!negative && !zero);
			OP_GTE: alu_result = data_t'(!negative);
			OP_EQ: alu_result = data_t'(zero);
			OP_NEQ: alu_result = data_t'(!zero);
			OP_AND: alu_result = op0 & op1;
			OP_OR: alu_result = op0 | op1;
			OP_XOR: alu_result = op0 ^ op1;
			OP_LSHIFT: alu_result = op0 << op1;
			OP_RSHIFT: alu_result = op0 >> op1;
			default: alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/stack_datapath.sv */
`default_nettype none
`timescale 1ns/10ps

module stack_datapath
	import stack_pkg::*;
#(
	parameter data_t STACK_TOP = 16'd8184
)
(
	input wire logic clk,
	input wire logic rst_n,
	input wire ctrl_t ctrl,
	input wire opcode_e opcode,
	input wire data_t param,
	input wire data_t alu_result,
	input wire word_t mem_read_value,
	output word_t top_of_stack,
	output data_t stack_pointer,
	output logic [1:0] slot,
	output logic tos_zero,
	output data_t memory_address,
	output word_t mem_write_value
);

	ip_t instruction_pointer;
	ip_t ip_next;
	ip_t word_base;
	data_t sp_next;
	word_t tos_next;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			instruction_pointer <= '1;
			stack_pointer <= STACK_TOP;
			top_of_stack <= '0;
		end
		else
		begin
			instruction_pointer <= ip_next;
			stack_pointer <= sp_next;
			top_of_stack <= tos_next;
		end
	end

	assign slot = instruction_pointer[1:0];
	assign word_base = {instruction_pointer[IP_WIDTH-1:2], 2'b00};
	assign tos_zero = (top_of_stack[DATA_WIDTH-1:0] == '0);

	always_comb
	begin
		case (ctrl.ip_sel)
			IP_NEXT:
			begin
				// Opcodes with a parameter use up the rest of the word
				if (opcode[4:3] == 2'b11)
					ip_next = word_base + ip_t'(4);
				else
					ip_next = instruction_pointer + ip_t'(1);
			end
			IP_BRANCH: ip_next = word_base + {{4{param[DATA_WIDTH-1]}}, param, 2'b00};
			default: ip_next = instruction_pointer;
		endcase
	end

	always_comb
	begin
		case (ctrl.sp_sel)
			SP_DECREMENT: sp_next = stack_pointer - data_t'(1);
			SP_INCREMENT: sp_next = stack_pointer + data_t'(1);
			default: sp_next = stack_pointer;
		endcase
	end

	always_comb
	begin
		case (ctrl.tos_sel)
			TOS_PARAM: tos_next = {{4{param[DATA_WIDTH-1]}}, param};
			// Tag bits ride along unchanged
			TOS_ALU_RESULT: tos_next = {top_of_stack[WORD_SIZE-1:DATA_WIDTH], alu_result};
			TOS_MEM_RESULT: tos_next = mem_read_value;
			default: tos_next = top_of_stack;
		endcase
	end

	always_comb
	begin
		case (ctrl.ma_sel)
			MA_IP: memory_address = ip_next[DATA_WIDTH+1:2];
			MA_SP: memory_address = stack_pointer;
			MA_TOS: memory_address = top_of_stack[DATA_WIDTH-1:0];
			default: memory_address = alu_result;
		endcase
	end

	assign mem_write_value = (ctrl.mw_sel == MW_MEM_READ) ? mem_read_value : top_of_stack;

endmodule

`default_nettype wire

/* design/stack_pkg.sv */
`default_nettype none

package stack_pkg;

	// Memory word, data path and opcode widths
	parameter int WORD_SIZE = 20;
	parameter int DATA_WIDTH = 16;
	parameter int SLOT_WIDTH = 5;
	// Two extra low bits pick the opcode slot within a word
	parameter int IP_WIDTH = WORD_SIZE + 2;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [IP_WIDTH-1:0] ip_t;

	// Opcodes 24 and above carry an immediate parameter
	typedef enum logic [SLOT_WIDTH-1:0] {
		OP_NOP = 5'd0,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_LSHIFT = 5'd19,
		OP_RSHIFT = 5'd20,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_e;

	typedef enum logic [2:0] {
		IADDR_ISSUE = 3'd0,
		DECODE = 3'd1,
		GOT_NOS = 3'd2,
		LOAD_TOS1 = 3'd3,
		PUSH_MEM_RESULT = 3'd4
	} state_e;

	typedef enum logic [1:0] {SP_CURRENT, SP_DECREMENT, SP_INCREMENT} sp_sel_e;
	typedef enum logic [1:0] {TOS_CURRENT, TOS_PARAM, TOS_ALU_RESULT, TOS_MEM_RESULT} tos_sel_e;
	typedef enum logic [1:0] {MA_IP, MA_SP, MA_TOS, MA_ALU} ma_sel_e;
	typedef enum logic {MW_TOS, MW_MEM_READ} mw_sel_e;
	typedef enum logic [1:0] {IP_CURRENT, IP_NEXT, IP_BRANCH} ip_sel_e;
	typedef enum logic {OP0_TOS, OP0_SP} op0_sel_e;
	typedef enum logic [1:0] {OP1_MEM_READ, OP1_PARAM, OP1_ONE} op1_sel_e;

	// Per-cycle control word from the sequencer
	typedef struct packed {
		sp_sel_e sp_sel;
		tos_sel_e tos_sel;
		ma_sel_e ma_sel;
		mw_sel_e mw_sel;
		ip_sel_e ip_sel;
		op0_sel_e op0_sel;
		op1_sel_e op1_sel;
		opcode_e alu_op;
		logic mem_write_enable;
		// Take the instruction straight off the read bus
		logic insn_from_mem;
	} ctrl_t;

endpackage

`default_nettype wire

/* lisp_core.f */
design/stack_pkg.sv
design/insn_align.sv
design/stack_alu.sv
design/control_fsm.sv
design/stack_datapath.sv
design/lisp_core.sv
testbench/lisp_core_properties.sv
testbench/tb_lisp_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_lisp_core -f lisp_core.f \
	--Mdir obj_dir -o sim_lisp_core

output=$(./obj_dir/sim_lisp_core) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

/* testbench/lisp_core_properties.sv */
`default_nettype none
`timescale 1ns/10ps

module lisp_core_properties
	import stack_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire data_t memory_address,
	input wire logic mem_write_enable
);

	// Nothing may be stored while the core is held in reset
	write_quiet_in_reset: assert property (
		@(posedge clk) !rst_n |-> !mem_write_enable
	) else $error("mem_write_enable high during reset");

	address_known: assert property (
		@(posedge clk) disable iff (!rst_n) !$isunknown(memory_address)
	) else $error("memory_address has unknown bits");

	// Every write state is followed by a read or fetch state
	no_back_to_back_write: assert property (
		@(posedge clk) disable iff (!rst_n) mem_write_enable |=> !mem_write_enable
	) else $error("memory writes on two consecutive cycles");

endmodule

bind lisp_core lisp_core_properties i_lisp_core_properties (
	.clk(clk),
	.rst_n(rst_n),
	.memory_address(memory_address),
	.mem_write_enable(mem_write_enable)
);

`default_nettype wire

/* testbench/tb_lisp_core.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_lisp_core
	import stack_pkg::*;
();

	localparam data_t STACK_TOP = 16'd1016;
	localparam int MEM_WORDS = 1024;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int QUIET_CYCLES = 40;
	localparam int MAX_STEPS = 2000;
	localparam int NUM_PROGRAMS = 4;
	localparam opcode_e BINARY_OPS [9] = '{OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT,
		OP_GTR, OP_GTE, OP_EQ, OP_NEQ};

	logic clk = 1'b0;
	logic rst_n;
	logic load_program;
	data_t memory_address;
	word_t mem_read_value = '0;
	word_t mem_write_value;
	logic mem_write_enable;

	word_t mem [MEM_WORDS];
	word_t prog [MEM_WORDS];
	data_t exp_addr [$];
	word_t exp_data [$];
	int write_count = 0;
	int compare_errors = 0;
	int check_errors = 0;
	int timeout_errors = 0;
	int seed = 33;

	// Assembler position inside the program image
	int asm_word;
	int asm_slot;
	word_t asm_buf;

	always #50 clk = ~clk;

	lisp_core #(
		.STACK_TOP(STACK_TOP)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.memory_address(memory_address),
		.mem_read_value(mem_read_value),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	function automatic logic [9:0] mem_index(int a);
		return 10'(a);
	endfunction

	// Registered read, the image is copied in while the core sits in reset
	always @(posedge clk)
	begin
		if (load_program)
		begin
			for (int a = 0; a < MEM_WORDS; a++)
				mem[mem_index(a)] <= prog[mem_index(a)];
		end
		else if (mem_write_enable)
			mem[memory_address[9:0]] <= mem_write_value;
		mem_read_value <= mem[memory_address[9:0]];
	end

	function automatic word_t fill_word(int a);
		return word_t'((a * 2654435) ^ (a << 11) ^ 32'h3c5a5);
	endfunction

	function automatic int rand_operand();
		return $random(seed) % 512;
	endfunction

	function automatic void flush_word();
		if (asm_slot != 0)
		begin
			prog[mem_index(asm_word)] = asm_buf;
			asm_word++;
			asm_slot = 0;
			asm_buf = '0;
		end
	endfunction

	function automatic void clear_program();
		for (int a = 0; a < MEM_WORDS; a++)
			prog[mem_index(a)] = fill_word(a);
		asm_word = 0;
		asm_slot = 0;
		asm_buf = '0;
	endfunction

	function automatic bit imm_fits(int width, int val);
		if (width == 0)
			return (val == 0);
		return (val >= -(1 << (width - 1))) && (val < (1 << (width - 1)));
	endfunction

	function automatic void emit_op(opcode_e op);
		asm_buf = asm_buf | (word_t'(op) << (15 - 5 * asm_slot));
		asm_slot++;
		if (asm_slot == 4)
			flush_word();
	endfunction

	// Immediate takes every bit below its opcode, pad with NOPs if it does not fit
	function automatic void emit_imm(opcode_e op, int val);
		int width;
		width = 15 - 5 * asm_slot;
		if (!imm_fits(width, val))
		begin
			flush_word();
			width = 15;
		end
		asm_buf = asm_buf | (word_t'(op) << width);
		if (width > 0)
			asm_buf = asm_buf | (word_t'(val) & ((word_t'(1) << width) - word_t'(1)));
		asm_slot = 4;
		flush_word();
	endfunction

	function automatic void emit_push(int val);
		emit_imm(OP_PUSH, val);
	endfunction

	// Branches start a word so the offset can be patched later
	function automatic int emit_branch(opcode_e op);
		int idx;
		flush_word();
		idx = asm_word;
		emit_imm(op, 0);
		return idx;
	endfunction

	function automatic void patch_branch(int idx);
		flush_word();
		prog[mem_index(idx)][14:0] = 15'(asm_word - idx);
	endfunction

	function automatic void emit_halt();
		flush_word();
		emit_imm(OP_GOTO, 0);
	endfunction

	function automatic int decode_param(word_t w, int width);
		int raw;
		if (width == 0)
			return 0;
		raw = int'(w & ((word_t'(1) << width) - word_t'(1)));
		if (raw >= (1 << (width - 1)))
			raw = raw - (1 << width);
		return raw;
	endfunction

	// TOS is the left operand, NOS the right
	function automatic data_t alu_model(opcode_e op, data_t a, data_t b);
		data_t diff;
		diff = a - b;
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return diff;
			OP_GTR: return (!diff[15] && diff != 16'd0) ? 16'd1 : 16'd0;
			OP_GTE: return diff[15] ? 16'd0 : 16'd1;
			OP_EQ: return (diff == 16'd0) ? 16'd1 : 16'd0;
			OP_NEQ: return (diff != 16'd0) ? 16'd1 : 16'd0;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_LSHIFT: return (b > 16'd15) ? 16'd0 : (a << b[3:0]);
			OP_RSHIFT: return (b > 16'd15) ? 16'd0 : (a >> b[3:0]);
			default: return 16'd0;
		endcase
	endfunction

	function automatic void record_write(data_t addr, word_t data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endfunction

	// ISA model, appends every memory write of the program in order
	function automatic void model_program();
		word_t ref_mem [MEM_WORDS];
		word_t w;
		word_t nos;
		word_t tos;
		opcode_e op;
		int word_idx;
		int slot;
		int param;
		int sp;
		int next_word;
		int next_slot;
		logic zero;

		for (int a = 0; a < MEM_WORDS; a++)
			ref_mem[mem_index(a)] = prog[mem_index(a)];
		tos = '0;
		sp = int'(STACK_TOP);
		word_idx = 0;
		slot = 0;
		for (int step = 0; step < MAX_STEPS; step++)
		begin
			w = ref_mem[mem_index(word_idx)];
			op = opcode_e'(5'(w >> (15 - 5 * slot)));
			param = decode_param(w, 15 - 5 * slot);
			if (op == OP_GOTO && param == 0 && slot == 0)
				break;
			if (int'(op) >= 24 || slot == 3)
			begin
				next_word = word_idx + 1;
				next_slot = 0;
			end
			else
			begin
				next_word = word_idx;
				next_slot = slot + 1;
			end
			case (op)
				OP_PUSH, OP_DUP:
				begin
					sp = sp - 1;
					ref_mem[mem_index(sp)] = tos;
					record_write(data_t'(sp), tos);
					if (op == OP_PUSH)
						tos = word_t'(param);
				end
				OP_POP:
				begin
					tos = ref_mem[mem_index(sp)];
					sp = sp + 1;
				end
				OP_LOAD:
					tos = ref_mem[tos[9:0]];
				OP_STORE:
				begin
					nos = ref_mem[mem_index(sp)];
					ref_mem[tos[9:0]] = nos;
					record_write(tos[15:0], nos);
					tos = ref_mem[mem_index(sp + 1)];
					sp = sp + 2;
				end
				OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
				OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
				begin
					nos = ref_mem[mem_index(sp)];
					tos = {tos[19:16], alu_model(op, tos[15:0], nos[15:0])};
					sp = sp + 1;
				end
				OP_GOTO:
				begin
					next_word = word_idx + param;
					next_slot = 0;
				end
				OP_BFALSE:
				begin
					zero = (tos[15:0] == 16'd0);
					tos = ref_mem[mem_index(sp)];
					sp = sp + 1;
					if (zero)
					begin
						next_word = word_idx + param;
						next_slot = 0;
					end
				end
				default: ;
			endcase
			word_idx = next_word;
			slot = next_slot;
		end
	endfunction

	task automatic build_program(input int which);
		int a;
		int b;
		int br;
		clear_program();
		case (which)
			0:
			begin
				emit_push(rand_operand());
				emit_push(rand_operand());
				emit_op(OP_ADD);
				emit_push(rand_operand());
				emit_op(OP_SUB);
				emit_push(600);
				emit_op(OP_STORE);
				emit_push(rand_operand());
				emit_push(rand_operand());
				emit_op(OP_SUB);
				emit_push(601);
				emit_op(OP_STORE);
			end
			1:
			begin
				for (int i = 0; i < 9; i++)
				begin
					// NOS is the shift amount
					if (BINARY_OPS[i] == OP_LSHIFT || BINARY_OPS[i] == OP_RSHIFT)
						a = $random(seed) & 15;
					else
						a = rand_operand();
					if (BINARY_OPS[i] == OP_EQ || BINARY_OPS[i] == OP_GTE)
						b = a;
					else
						b = rand_operand();
					emit_push(a);
					emit_push(b);
					emit_op(BINARY_OPS[i]);
					emit_push(610 + i);
					emit_op(OP_STORE);
				end
			end
			2:
			begin
				emit_push(0);
				br = emit_branch(OP_BFALSE);
				emit_push(77);
				emit_push(620);
				emit_op(OP_STORE);
				patch_branch(br);
				emit_push(11);
				emit_push(621);
				emit_op(OP_STORE);
				emit_push(($random(seed) & 255) + 1);
				br = emit_branch(OP_BFALSE);
				emit_push(22);
				emit_push(622);
				emit_op(OP_STORE);
				patch_branch(br);
				br = emit_branch(OP_GOTO);
				emit_push(33);
				emit_push(623);
				emit_op(OP_STORE);
				patch_branch(br);
				emit_push(44);
				emit_push(624);
				emit_op(OP_STORE);
			end
			default:
			begin
				emit_push(rand_operand());
				emit_op(OP_DUP);
				emit_push(630);
				emit_op(OP_STORE);
				emit_push(631);
				emit_op(OP_STORE);
				emit_push(rand_operand());
				emit_push(rand_operand());
				emit_op(OP_POP);
				emit_push(632);
				emit_op(OP_STORE);
				emit_push(700);
				emit_op(OP_LOAD);
				emit_push(633);
				emit_op(OP_STORE);
				emit_push(630);
				emit_op(OP_LOAD);
				emit_push(634);
				emit_op(OP_STORE);
				emit_push(700 + ($random(seed) & 63));
				emit_op(OP_LOAD);
				emit_op(OP_DUP);
				emit_op(OP_ADD);
				emit_push(635);
				emit_op(OP_STORE);
			end
		endcase
		emit_halt();
	endtask

	task automatic run_program();
		int cycles;
		model_program();
		@(posedge clk);
		rst_n <= 1'b0;
		load_program <= 1'b1;
		@(posedge clk);
		load_program <= 1'b0;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (memory_address !== 16'd0 || mem_write_enable !== 1'b0)
		begin
			$display("** Error: time %0t: first cycle after reset shows address %0d, write %b",
				$time, memory_address, mem_write_enable);
			check_errors++;
		end
		cycles = 0;
		while (write_count < exp_addr.size() && cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		if (write_count < exp_addr.size())
		begin
			$display("Timed out waiting for memory writes, saw %0d of %0d",
				write_count, exp_addr.size());
			timeout_errors++;
		end
		// Halted program sits in its GOTO loop, any write now is extra
		repeat (QUIET_CYCLES) @(posedge clk);
	endtask

	always @(negedge clk)
	begin
		if (rst_n && mem_write_enable)
		begin
			if (write_count >= exp_addr.size())
			begin
				$display("Unexpected memory write to address %0d at time %0t",
					memory_address, $time);
				compare_errors++;
			end
			else
			begin
				if (memory_address !== exp_addr[write_count])
				begin
					$display("** Error: time %0t: write %0d address %0d, expected %0d",
						$time, write_count, memory_address, exp_addr[write_count]);
					compare_errors++;
				end
				if (mem_write_value !== exp_data[write_count])
				begin
					$display("** Error: time %0t: write %0d data %h, expected %h",
						$time, write_count, mem_write_value, exp_data[write_count]);
					compare_errors++;
				end
			end
			write_count++;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		load_program = 1'b0;
		for (int p = 0; p < NUM_PROGRAMS && timeout_errors == 0; p++)
		begin
			build_program(p);
			run_program();
		end
		$display("Errors: %0d compare, %0d check, %0d timeout, %0d of %0d writes seen",
			compare_errors, check_errors, timeout_errors, write_count, exp_addr.size());
		if (compare_errors == 0 && check_errors == 0 && timeout_errors == 0
			&& write_count == exp_addr.size())
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
